// File: common/xpu_defines.svh
// widths, header byte offsets, register map, filter bits and clock rate
`ifndef XPU_DEFINES_SVH
`define XPU_DEFINES_SVH

`define XPU_MAC_ADDR_W      48
`define XPU_TSF_W           64
`define XPU_REG_DATA_W      32
`define XPU_REG_ADDR_W      3
`define XPU_CLK_PER_US      100
`define XPU_FILTER_CFG_W    5
`define XPU_PKT_LEN_W       16

// last byte index of each header field within the mpdu
`define XPU_FC_LAST_BYTE    3
`define XPU_ADDR1_LAST_BYTE 9
`define XPU_ADDR2_LAST_BYTE 15
`define XPU_ADDR3_LAST_BYTE 21

// register word addresses
`define XPU_REG_MAC_LO      3'd0
`define XPU_REG_MAC_HI      3'd1
`define XPU_REG_BSSID_LO    3'd2
`define XPU_REG_BSSID_HI    3'd3
`define XPU_REG_FILTER      3'd4
`define XPU_REG_MAX_LEN     3'd5
`define XPU_REG_TSF_LO      3'd6
`define XPU_REG_TSF_HI      3'd7

// filter configuration bit positions
`define XPU_FLT_PASS_ALL        0
`define XPU_FLT_DROP_NOT_ME     1
`define XPU_FLT_DROP_OTHER_BSS  2
`define XPU_FLT_DROP_LONG       3
`define XPU_FLT_DROP_HT         4

`endif

// File: common/xpu_pkg.sv
// frame-control/duration field struct and its raw-word union
package xpu_pkg;

    // first header word, bit 0 is the first bit of byte 0
    typedef struct packed {
        logic [15:0] duration;
        logic        order;
        logic        protected_frame;
        logic        more_data;
        logic        power_manage;
        logic        retry;
        logic        more_frag;
        logic        from_ds;
        logic        to_ds;
        logic [3:0]  subtype;
        logic [1:0]  frame_type;
        logic [1:0]  version;
    } fc_fields_t;

    // parser fills the raw word byte by byte, filter decodes fields
    typedef union packed {
        logic [31:0] raw;
        fc_fields_t  fields;
    } fc_di_u;

endpackage

// File: verilog/xpu_regs.sv
// configuration registers written by a single-cycle strobe, tsf load strobe
`include "xpu_defines.svh"

module xpu_regs (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic                           reg_wr_i,
    input  logic [`XPU_REG_ADDR_W-1:0]     reg_addr_i,
    input  logic [`XPU_REG_DATA_W-1:0]     reg_wdata_i,
    output logic [`XPU_MAC_ADDR_W-1:0]     mac_addr_o,
    output logic [`XPU_MAC_ADDR_W-1:0]     bssid_o,
    output logic [`XPU_FILTER_CFG_W-1:0]   filter_cfg_o,
    output logic [`XPU_PKT_LEN_W-1:0]      max_len_o,
    output logic                           tsf_load_o,
    output logic [`XPU_TSF_W-1:0]          tsf_load_val_o
);

    localparam int ADDR_HI_W = `XPU_MAC_ADDR_W - `XPU_REG_DATA_W;
    localparam int TSF_HI_W  = `XPU_TSF_W - `XPU_REG_DATA_W;

    logic [`XPU_REG_DATA_W-1:0]   mac_lo_q;
    logic [ADDR_HI_W-1:0]         mac_hi_q;
    logic [`XPU_REG_DATA_W-1:0]   bssid_lo_q;
    logic [ADDR_HI_W-1:0]         bssid_hi_q;
    logic [`XPU_FILTER_CFG_W-1:0] filter_cfg_q;
    logic [`XPU_PKT_LEN_W-1:0]    max_len_q;
    logic [`XPU_REG_DATA_W-1:0]   tsf_lo_q;
    logic [TSF_HI_W-1:0]          tsf_hi_q;
    logic                         tsf_load_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mac_lo_q     <= '0;
            mac_hi_q     <= '0;
            bssid_lo_q   <= '0;
            bssid_hi_q   <= '0;
            filter_cfg_q <= '0;
            max_len_q    <= '0;
            tsf_lo_q     <= '0;
            tsf_hi_q     <= '0;
            tsf_load_q   <= 1'b0;
        end else begin
            // high word write commits the whole 64-bit load value
            tsf_load_q <= reg_wr_i && (reg_addr_i == `XPU_REG_TSF_HI);
            if (reg_wr_i) begin
                case (reg_addr_i)
                    `XPU_REG_MAC_LO:   mac_lo_q     <= reg_wdata_i;
                    `XPU_REG_MAC_HI:   mac_hi_q     <= reg_wdata_i[ADDR_HI_W-1:0];
                    `XPU_REG_BSSID_LO: bssid_lo_q   <= reg_wdata_i;
                    `XPU_REG_BSSID_HI: bssid_hi_q   <= reg_wdata_i[ADDR_HI_W-1:0];
                    `XPU_REG_FILTER:   filter_cfg_q <= reg_wdata_i[`XPU_FILTER_CFG_W-1:0];
                    `XPU_REG_MAX_LEN:  max_len_q    <= reg_wdata_i[`XPU_PKT_LEN_W-1:0];
                    `XPU_REG_TSF_LO:   tsf_lo_q     <= reg_wdata_i;
                    `XPU_REG_TSF_HI:   tsf_hi_q     <= reg_wdata_i[TSF_HI_W-1:0];
                endcase
            end
        end
    end

    assign mac_addr_o     = {mac_hi_q, mac_lo_q};
    assign bssid_o        = {bssid_hi_q, bssid_lo_q};
    assign filter_cfg_o   = filter_cfg_q;
    assign max_len_o      = max_len_q;
    assign tsf_load_o     = tsf_load_q;
    assign tsf_load_val_o = {tsf_hi_q, tsf_lo_q};

    // host side must drive a defined address with every write strobe
    a_wr_addr_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        reg_wr_i |-> !$isunknown(reg_addr_i));

endmodule

// File: verilog/tsf_timer.sv
// 64-bit tsf microsecond counter with 1 MHz pulse and register load
`include "xpu_defines.svh"

module tsf_timer (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  tsf_load_i,
    input  logic [`XPU_TSF_W-1:0] tsf_load_val_i,
    output logic [`XPU_TSF_W-1:0] tsf_runtime_val_o,
    output logic                  tsf_pulse_1m_o
);

    localparam int PRESC_W = $clog2(`XPU_CLK_PER_US);
    localparam logic [PRESC_W-1:0] PRESC_LAST = PRESC_W'(`XPU_CLK_PER_US - 1);

    logic [PRESC_W-1:0]    presc_q;
    logic [`XPU_TSF_W-1:0] tsf_q;
    logic                  pulse_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            presc_q <= '0;
            tsf_q   <= '0;
            pulse_q <= 1'b0;
        end else if (tsf_load_i) begin
            // load restarts the microsecond from zero
            presc_q <= '0;
            tsf_q   <= tsf_load_val_i;
            pulse_q <= 1'b0;
        end else if (presc_q == PRESC_LAST) begin
            presc_q <= '0;
            tsf_q   <= tsf_q + 1'b1;
            pulse_q <= 1'b1;
        end else begin
            presc_q <= presc_q + 1'b1;
            pulse_q <= 1'b0;
        end
    end

    // pulse and counter step land in the same cycle
    assign tsf_runtime_val_o = tsf_q;
    assign tsf_pulse_1m_o    = pulse_q;

    a_pulse_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        tsf_pulse_1m_o |=> !tsf_pulse_1m_o);

endmodule

// File: rx_parse/rx_hdr_parse.sv
// 802.11 mac header byte parser for frame control/duration and addr1-3
`include "xpu_defines.svh"

module rx_hdr_parse (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        sig_valid_i,
    input  logic                        byte_in_strobe_i,
    input  logic [7:0]                  byte_in_i,
    input  logic [`XPU_PKT_LEN_W-1:0]   byte_count_i,
    output xpu_pkg::fc_di_u             fc_di_o,
    output logic                        fc_di_valid_o,
    output logic [`XPU_MAC_ADDR_W-1:0]  addr1_o,
    output logic                        addr1_valid_o,
    output logic [`XPU_MAC_ADDR_W-1:0]  addr2_o,
    output logic                        addr2_valid_o,
    output logic [`XPU_MAC_ADDR_W-1:0]  addr3_o,
    output logic                        addr3_valid_o
);

    localparam logic [`XPU_PKT_LEN_W-1:0] FC_LAST     = `XPU_FC_LAST_BYTE;
    localparam logic [`XPU_PKT_LEN_W-1:0] ADDR1_FIRST = `XPU_FC_LAST_BYTE + 1;
    localparam logic [`XPU_PKT_LEN_W-1:0] ADDR1_LAST  = `XPU_ADDR1_LAST_BYTE;
    localparam logic [`XPU_PKT_LEN_W-1:0] ADDR2_FIRST = `XPU_ADDR1_LAST_BYTE + 1;
    localparam logic [`XPU_PKT_LEN_W-1:0] ADDR2_LAST  = `XPU_ADDR2_LAST_BYTE;
    localparam logic [`XPU_PKT_LEN_W-1:0] ADDR3_FIRST = `XPU_ADDR2_LAST_BYTE + 1;
    localparam logic [`XPU_PKT_LEN_W-1:0] ADDR3_LAST  = `XPU_ADDR3_LAST_BYTE;

    logic                      in_fc;
    logic                      in_addr1;
    logic                      in_addr2;
    logic                      in_addr3;
    logic [`XPU_PKT_LEN_W-1:0] addr1_ofs;
    logic [`XPU_PKT_LEN_W-1:0] addr2_ofs;
    logic [`XPU_PKT_LEN_W-1:0] addr3_ofs;

    // which field owns the current byte
    assign in_fc    = byte_in_strobe_i && (byte_count_i <= FC_LAST);
    assign in_addr1 = byte_in_strobe_i && (byte_count_i >= ADDR1_FIRST)
                      && (byte_count_i <= ADDR1_LAST);
    assign in_addr2 = byte_in_strobe_i && (byte_count_i >= ADDR2_FIRST)
                      && (byte_count_i <= ADDR2_LAST);
    assign in_addr3 = byte_in_strobe_i && (byte_count_i >= ADDR3_FIRST)
                      && (byte_count_i <= ADDR3_LAST);

    // byte position inside its field
    assign addr1_ofs = byte_count_i - ADDR1_FIRST;
    assign addr2_ofs = byte_count_i - ADDR2_FIRST;
    assign addr3_ofs = byte_count_i - ADDR3_FIRST;

    // first received byte lands in the least significant byte
    always_ff @(posedge clk_i) begin
        if (sig_valid_i) begin
            fc_di_o.raw <= '0;
            addr1_o     <= '0;
            addr2_o     <= '0;
            addr3_o     <= '0;
        end else begin
            if (in_fc)
                fc_di_o.raw[{byte_count_i[1:0], 3'b000} +: 8] <= byte_in_i;
            if (in_addr1)
                addr1_o[{addr1_ofs[2:0], 3'b000} +: 8] <= byte_in_i;
            if (in_addr2)
                addr2_o[{addr2_ofs[2:0], 3'b000} +: 8] <= byte_in_i;
            if (in_addr3)
                addr3_o[{addr3_ofs[2:0], 3'b000} +: 8] <= byte_in_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fc_di_valid_o <= 1'b0;
            addr1_valid_o <= 1'b0;
            addr2_valid_o <= 1'b0;
            addr3_valid_o <= 1'b0;
        end else if (sig_valid_i) begin
            fc_di_valid_o <= 1'b0;
            addr1_valid_o <= 1'b0;
            addr2_valid_o <= 1'b0;
            addr3_valid_o <= 1'b0;
        end else begin
            fc_di_valid_o <= byte_in_strobe_i && (byte_count_i == FC_LAST);
            addr1_valid_o <= byte_in_strobe_i && (byte_count_i == ADDR1_LAST);
            addr2_valid_o <= byte_in_strobe_i && (byte_count_i == ADDR2_LAST);
            addr3_valid_o <= byte_in_strobe_i && (byte_count_i == ADDR3_LAST);
        end
    end

    // a new frame never starts on a byte cycle, that byte would be lost
    a_sig_not_on_byte: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        sig_valid_i |-> !byte_in_strobe_i);

endmodule

// File: rx_parse/pkt_filter.sv
// receive filter decision for dma blocking and the for-me flag
`include "xpu_defines.svh"

module pkt_filter (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          sig_valid_i,
    input  logic [`XPU_PKT_LEN_W-1:0]     pkt_len_i,
    input  logic                          ht_unsupport_i,
    input  xpu_pkg::fc_di_u               fc_di_i,
    input  logic [`XPU_MAC_ADDR_W-1:0]    addr1_i,
    input  logic [`XPU_MAC_ADDR_W-1:0]    addr2_i,
    input  logic [`XPU_MAC_ADDR_W-1:0]    addr3_i,
    input  logic                          addr3_valid_i,
    input  logic [`XPU_MAC_ADDR_W-1:0]    mac_addr_i,
    input  logic [`XPU_MAC_ADDR_W-1:0]    bssid_i,
    input  logic [`XPU_FILTER_CFG_W-1:0]  filter_cfg_i,
    input  logic [`XPU_PKT_LEN_W-1:0]     max_len_i,
    output logic                          block_rx_dma_to_ps_o,
    output logic                          block_rx_dma_to_ps_valid_o,
    output logic                          pkt_for_me_o
);

    localparam logic [1:0] FC_TYPE_DATA = 2'd2;

    xpu_pkg::fc_fields_t          fc;
    logic [`XPU_PKT_LEN_W-1:0]    pkt_len_q;
    logic                         ht_unsupport_q;
    logic [`XPU_MAC_ADDR_W-1:0]   bss_addr;
    logic                         not_for_me;
    logic                         other_bss;
    logic                         too_long;
    logic                         block_next;

    assign fc = fc_di_i.fields;

    // address that carries the bssid for each to/from-ds pair
    always_comb begin
        case ({fc.to_ds, fc.from_ds})
            2'b00:   bss_addr = addr3_i;
            2'b10:   bss_addr = addr1_i;
            2'b01:   bss_addr = addr2_i;
            // wds frames have no bssid to compare against
            default: bss_addr = bssid_i;
        endcase
    end

    assign not_for_me = (addr1_i != mac_addr_i) && (addr1_i != '1);
    assign other_bss  = (fc.frame_type == FC_TYPE_DATA) && (bss_addr != bssid_i);
    assign too_long   = pkt_len_q > max_len_i;

    assign block_next = !filter_cfg_i[`XPU_FLT_PASS_ALL]
        && ((filter_cfg_i[`XPU_FLT_DROP_NOT_ME]    && not_for_me)
         || (filter_cfg_i[`XPU_FLT_DROP_OTHER_BSS] && other_bss)
         || (filter_cfg_i[`XPU_FLT_DROP_LONG]      && too_long)
         || (filter_cfg_i[`XPU_FLT_DROP_HT]        && ht_unsupport_q));

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pkt_len_q                  <= '0;
            ht_unsupport_q             <= 1'b0;
            block_rx_dma_to_ps_o       <= 1'b0;
            block_rx_dma_to_ps_valid_o <= 1'b0;
        end else begin
            // signal field info is held for the whole frame
            if (sig_valid_i) begin
                pkt_len_q      <= pkt_len_i;
                ht_unsupport_q <= ht_unsupport_i;
            end
            // decide once addr3 completes, hold until next frame decision
            block_rx_dma_to_ps_valid_o <= addr3_valid_i;
            if (addr3_valid_i)
                block_rx_dma_to_ps_o <= block_next;
        end
    end

    assign pkt_for_me_o = (addr1_i == mac_addr_i);

    a_decision_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        block_rx_dma_to_ps_valid_o |=> !block_rx_dma_to_ps_valid_o);

endmodule

// File: verilog/xpu_top.sv
// receive-side lower mac top with registers, tsf, header parser and filter
`include "xpu_defines.svh"

module xpu_top (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          reg_wr_i,
    input  logic [`XPU_REG_ADDR_W-1:0]    reg_addr_i,
    input  logic [`XPU_REG_DATA_W-1:0]    reg_wdata_i,
    input  logic                          pkt_header_valid_i,
    input  logic                          pkt_header_valid_strobe_i,
    input  logic [`XPU_PKT_LEN_W-1:0]     pkt_len_i,
    input  logic                          ht_unsupport_i,
    input  logic                          byte_in_strobe_i,
    input  logic [7:0]                    byte_in_i,
    input  logic [`XPU_PKT_LEN_W-1:0]     byte_count_i,
    output xpu_pkg::fc_di_u               fc_di_o,
    output logic                          fc_di_valid_o,
    output logic [`XPU_MAC_ADDR_W-1:0]    addr1_o,
    output logic                          addr1_valid_o,
    output logic [`XPU_MAC_ADDR_W-1:0]    addr2_o,
    output logic                          addr2_valid_o,
    output logic [`XPU_MAC_ADDR_W-1:0]    addr3_o,
    output logic                          addr3_valid_o,
    output logic                          pkt_for_me_o,
    output logic                          block_rx_dma_to_ps_o,
    output logic                          block_rx_dma_to_ps_valid_o,
    output logic [`XPU_TSF_W-1:0]         tsf_runtime_val_o,
    output logic                          tsf_pulse_1m_o
);

    logic [`XPU_MAC_ADDR_W-1:0]   mac_addr;
    logic [`XPU_MAC_ADDR_W-1:0]   bssid;
    logic [`XPU_FILTER_CFG_W-1:0] filter_cfg;
    logic [`XPU_PKT_LEN_W-1:0]    max_len;
    logic                         tsf_load;
    logic [`XPU_TSF_W-1:0]        tsf_load_val;
    logic                         sig_valid;

    // good signal field starts a new frame
    assign sig_valid = pkt_header_valid_strobe_i & pkt_header_valid_i;

    xpu_regs xpu_regs_i (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .reg_wr_i       (reg_wr_i),
        .reg_addr_i     (reg_addr_i),
        .reg_wdata_i    (reg_wdata_i),
        .mac_addr_o     (mac_addr),
        .bssid_o        (bssid),
        .filter_cfg_o   (filter_cfg),
        .max_len_o      (max_len),
        .tsf_load_o     (tsf_load),
        .tsf_load_val_o (tsf_load_val)
    );

    tsf_timer tsf_timer_i (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .tsf_load_i        (tsf_load),
        .tsf_load_val_i    (tsf_load_val),
        .tsf_runtime_val_o (tsf_runtime_val_o),
        .tsf_pulse_1m_o    (tsf_pulse_1m_o)
    );

    rx_hdr_parse rx_hdr_parse_i (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .sig_valid_i      (sig_valid),
        .byte_in_strobe_i (byte_in_strobe_i),
        .byte_in_i        (byte_in_i),
        .byte_count_i     (byte_count_i),
        .fc_di_o          (fc_di_o),
        .fc_di_valid_o    (fc_di_valid_o),
        .addr1_o          (addr1_o),
        .addr1_valid_o    (addr1_valid_o),
        .addr2_o          (addr2_o),
        .addr2_valid_o    (addr2_valid_o),
        .addr3_o          (addr3_o),
        .addr3_valid_o    (addr3_valid_o)
    );

    pkt_filter pkt_filter_i (
        .clk_i                      (clk_i),
        .rst_n_i                    (rst_n_i),
        .sig_valid_i                (sig_valid),
        .pkt_len_i                  (pkt_len_i),
        .ht_unsupport_i             (ht_unsupport_i),
        .fc_di_i                    (fc_di_o),
        .addr1_i                    (addr1_o),
        .addr2_i                    (addr2_o),
        .addr3_i                    (addr3_o),
        .addr3_valid_i              (addr3_valid_o),
        .mac_addr_i                 (mac_addr),
        .bssid_i                    (bssid),
        .filter_cfg_i               (filter_cfg),
        .max_len_i                  (max_len),
        .block_rx_dma_to_ps_o       (block_rx_dma_to_ps_o),
        .block_rx_dma_to_ps_valid_o (block_rx_dma_to_ps_valid_o),
        .pkt_for_me_o               (pkt_for_me_o)
    );

endmodule

// File: tb/tb_clkgen.sv
// testbench clock source and power-on reset generator
module tb_clkgen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    // reset held low for 8 rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (8) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

// File: tb/tb_xpu.sv
// random frame and register stimulus, reference model, checks and final report
`include "xpu_defines.svh"

module tb_xpu;

    localparam int N_FRAMES       = 200;
    localparam int TIMEOUT_CYCLES = N_FRAMES * 120 + 3000;

    logic        clk;
    logic        rst_n;
    logic        reg_wr_i;
    logic [2:0]  reg_addr_i;
    logic [31:0] reg_wdata_i;
    logic        pkt_header_valid_i;
    logic        pkt_header_valid_strobe_i;
    logic [15:0] pkt_len_i;
    logic        ht_unsupport_i;
    logic        byte_in_strobe_i;
    logic [7:0]  byte_in_i;
    logic [15:0] byte_count_i;
    logic [31:0] fc_di;
    logic        fc_di_valid;
    logic [47:0] addr1;
    logic        addr1_valid;
    logic [47:0] addr2;
    logic        addr2_valid;
    logic [47:0] addr3;
    logic        addr3_valid;
    logic        pkt_for_me;
    logic        block_dma;
    logic        block_dma_valid;
    logic [63:0] tsf_val;
    logic        tsf_pulse;

    int          err_val;
    int          err_proto;
    int          cycles;
    int          n_dec;
    int          armed;
    logic        for_me_live;
    logic        for_me_exp;
    logic        expect_now;
    logic [3:0]  valids_next;
    logic [3:0]  valids_exp;
    logic [47:0] mac;
    logic [47:0] bssid;
    logic [15:0] max_len;
    logic [4:0]  cfg;
    logic [31:0] exp_fc;
    logic [47:0] exp_a1;
    logic [47:0] exp_a2;
    logic [47:0] exp_a3;
    logic        exp_block;
    logic [7:0]  hdr [0:39];

    tb_clkgen clkgen (.clk_o(clk), .rst_n_o(rst_n));

    xpu_top UUT (
        .clk_i(clk), .rst_n_i(rst_n),
        .reg_wr_i(reg_wr_i), .reg_addr_i(reg_addr_i), .reg_wdata_i(reg_wdata_i),
        .pkt_header_valid_i(pkt_header_valid_i),
        .pkt_header_valid_strobe_i(pkt_header_valid_strobe_i),
        .pkt_len_i(pkt_len_i), .ht_unsupport_i(ht_unsupport_i),
        .byte_in_strobe_i(byte_in_strobe_i), .byte_in_i(byte_in_i),
        .byte_count_i(byte_count_i),
        .fc_di_o(fc_di), .fc_di_valid_o(fc_di_valid),
        .addr1_o(addr1), .addr1_valid_o(addr1_valid),
        .addr2_o(addr2), .addr2_valid_o(addr2_valid),
        .addr3_o(addr3), .addr3_valid_o(addr3_valid),
        .pkt_for_me_o(pkt_for_me),
        .block_rx_dma_to_ps_o(block_dma), .block_rx_dma_to_ps_valid_o(block_dma_valid),
        .tsf_runtime_val_o(tsf_val), .tsf_pulse_1m_o(tsf_pulse)
    );

    function automatic logic [47:0] rand48();
        logic [31:0] h;
        logic [31:0] l;
        h = $urandom();
        l = $urandom();
        return {h[15:0], l};
    endfunction

    // drop decision from the filter rules
    function automatic logic predict_block(input logic [31:0] fc, input logic [47:0] a1,
                                           input logic [47:0] a2, input logic [47:0] a3,
                                           input logic [15:0] len, input logic ht);
        logic        not_me;
        logic        other;
        logic [47:0] pick;
        not_me = (a1 != mac) && (a1 != {48{1'b1}});
        case ({fc[8], fc[9]})
            2'b00:   pick = a3;
            2'b10:   pick = a1;
            2'b01:   pick = a2;
            default: pick = bssid;
        endcase
        other = (fc[3:2] == 2'd2) && (pick != bssid);
        return !cfg[0] && ((cfg[1] && not_me) || (cfg[2] && other)
                           || (cfg[3] && (len > max_len)) || (cfg[4] && ht));
    endfunction

    task automatic reg_write(input logic [2:0] addr, input logic [31:0] data);
        @(posedge clk);
        reg_wr_i    <= 1'b1;
        reg_addr_i  <= addr;
        reg_wdata_i <= data;
        @(posedge clk);
        reg_wr_i    <= 1'b0;
    endtask

    // one microsecond of cycles, pulse and step only on the last
    task automatic check_us_period(input logic [63:0] base);
        for (int k = 1; k <= 100; k++) begin
            @(negedge clk);
            if (k < 100) begin
                if (tsf_pulse !== 1'b0) begin
                    $display("ERR tsf_pulse_1m_o exp 0 got %h", tsf_pulse);
                    err_val++;
                end
                if (tsf_val !== base) begin
                    $display("ERR tsf_runtime_val_o exp %h got %h", base, tsf_val);
                    err_val++;
                end
            end else begin
                if (tsf_pulse !== 1'b1) begin
                    $display("ERR tsf_pulse_1m_o exp 1 got %h", tsf_pulse);
                    err_val++;
                end
                if (tsf_val !== base + 64'd1) begin
                    $display("ERR tsf_runtime_val_o exp %h got %h", base + 64'd1, tsf_val);
                    err_val++;
                end
            end
        end
    endtask

    task automatic send_frame();
        logic [31:0] r;
        logic [1:0]  t;
        logic        ht;
        int          len;
        int          gap;
        r = $urandom();
        t = ($urandom() % 4 < 3) ? 2'd2 : r[3:2];
        exp_fc = {r[31:4], t, r[1:0]};
        case ($urandom() % 4)
            0, 1:    exp_a1 = mac;
            2:       exp_a1 = {48{1'b1}};
            default: exp_a1 = rand48();
        endcase
        exp_a2 = ($urandom() % 3 < 2) ? bssid : rand48();
        exp_a3 = ($urandom() % 3 < 2) ? bssid : rand48();
        len = 24 + int'($urandom() % 17);
        r = $urandom();
        ht = r[0];
        for (int i = 0; i < 40; i++) begin
            r = $urandom();
            hdr[i] = r[7:0];
        end
        for (int i = 0; i < 4; i++)
            hdr[i] = exp_fc[8*i +: 8];
        for (int i = 0; i < 6; i++) begin
            hdr[4 + i]  = exp_a1[8*i +: 8];
            hdr[10 + i] = exp_a2[8*i +: 8];
            hdr[16 + i] = exp_a3[8*i +: 8];
        end
        exp_block = predict_block(exp_fc, exp_a1, exp_a2, exp_a3, 16'(len), ht);
        @(posedge clk);
        pkt_header_valid_strobe_i <= 1'b1;
        pkt_header_valid_i        <= 1'b1;
        pkt_len_i                 <= 16'(len);
        ht_unsupport_i            <= ht;
        @(posedge clk);
        pkt_header_valid_strobe_i <= 1'b0;
        pkt_header_valid_i        <= 1'b0;
        for (int i = 0; i < len; i++) begin
            gap = int'($urandom() % 2);
            repeat (gap) begin
                byte_in_strobe_i <= 1'b0;
                @(posedge clk);
            end
            byte_in_strobe_i <= 1'b1;
            byte_in_i        <= hdr[i];
            byte_count_i     <= 16'(i);
            @(posedge clk);
        end
        byte_in_strobe_i <= 1'b0;
        repeat (3) @(posedge clk);
    endtask

    always @(posedge clk) cycles <= cycles + 1;

    initial begin
        wait (cycles >= TIMEOUT_CYCLES);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("errors: value %0d, protocol %0d", err_val, err_proto);
        $display("TEST FAILED");
        $finish;
    end

    // field, for-me and decision checks, sampled away from the driving edge
    always @(negedge clk) begin
        if (rst_n) begin
            expect_now = 1'b0;
            if (armed > 0) begin
                armed = armed - 1;
                if (armed == 0) begin
                    expect_now = 1'b1;
                    armed = -1;
                end
            end
            if (byte_in_strobe_i && byte_count_i == `XPU_ADDR3_LAST_BYTE)
                armed = 2;
            // each field valid follows its last byte by one cycle
            valids_exp = valids_next;
            valids_next = {byte_in_strobe_i && byte_count_i == `XPU_FC_LAST_BYTE,
                           byte_in_strobe_i && byte_count_i == `XPU_ADDR1_LAST_BYTE,
                           byte_in_strobe_i && byte_count_i == `XPU_ADDR2_LAST_BYTE,
                           byte_in_strobe_i && byte_count_i == `XPU_ADDR3_LAST_BYTE};
            if ({fc_di_valid, addr1_valid, addr2_valid, addr3_valid} !== valids_exp) begin
                $display("ERR {fc_di,addr1,addr2,addr3}_valid_o exp %h got %h", valids_exp,
                         {fc_di_valid, addr1_valid, addr2_valid, addr3_valid});
                err_val++;
            end
            if (pkt_header_valid_strobe_i && pkt_header_valid_i)
                for_me_live = 1'b0;
            if (fc_di_valid && fc_di !== exp_fc) begin
                $display("ERR fc_di_o exp %h got %h", exp_fc, fc_di);
                err_val++;
            end
            if (addr1_valid) begin
                for_me_live = 1'b1;
                for_me_exp = (exp_a1 == mac);
                if (addr1 !== exp_a1) begin
                    $display("ERR addr1_o exp %h got %h", exp_a1, addr1);
                    err_val++;
                end
            end
            if (addr2_valid && addr2 !== exp_a2) begin
                $display("ERR addr2_o exp %h got %h", exp_a2, addr2);
                err_val++;
            end
            if (addr3_valid && addr3 !== exp_a3) begin
                $display("ERR addr3_o exp %h got %h", exp_a3, addr3);
                err_val++;
            end
            if (for_me_live && pkt_for_me !== for_me_exp) begin
                $display("ERR pkt_for_me_o exp %h got %h", for_me_exp, pkt_for_me);
                err_val++;
            end
            if (block_dma_valid) begin
                n_dec++;
                if (!expect_now) begin
                    $display("decision strobe came without a frame reaching byte 21");
                    err_proto++;
                end else if (block_dma !== exp_block) begin
                    $display("ERR block_rx_dma_to_ps_o exp %h got %h", exp_block, block_dma);
                    err_val++;
                end
            end else if (expect_now) begin
                $display("decision strobe missing two cycles after byte 21");
                err_proto++;
            end
        end
    end

    initial begin
        logic [31:0] lo;
        logic [31:0] hi;
        logic [31:0] r;
        logic [63:0] base;
        void'($urandom(32'ha596));
        err_val = 0;
        err_proto = 0;
        cycles = 0;
        n_dec = 0;
        armed = -1;
        for_me_live = 1'b0;
        for_me_exp = 1'b0;
        valids_next = '0;
        valids_exp = '0;
        exp_fc = '0;
        exp_a1 = '0;
        exp_a2 = '0;
        exp_a3 = '0;
        exp_block = 1'b0;
        mac = '0;
        bssid = '0;
        max_len = '0;
        cfg = '0;
        reg_wr_i = 1'b0;
        reg_addr_i = '0;
        reg_wdata_i = '0;
        pkt_header_valid_i = 1'b0;
        pkt_header_valid_strobe_i = 1'b0;
        pkt_len_i = '0;
        ht_unsupport_i = 1'b0;
        byte_in_strobe_i = 1'b0;
        byte_in_i = '0;
        byte_count_i = '0;

        @(posedge rst_n);
        @(negedge clk);
        if (block_dma !== 1'b0 || block_dma_valid !== 1'b0 || tsf_pulse !== 1'b0) begin
            $display("filter or timer outputs not low after reset");
            err_proto++;
        end
        if (tsf_val !== 64'd0) begin
            $display("ERR tsf_runtime_val_o exp %h got %h", 64'd0, tsf_val);
            err_val++;
        end

        // free-running microsecond ticks counted from reset release
        base = 64'd0;
        repeat (3) begin
            check_us_period(base);
            base = base + 64'd1;
        end

        // timer load through the register pair
        lo = $urandom();
        hi = $urandom();
        reg_write(`XPU_REG_TSF_LO, lo);
        reg_write(`XPU_REG_TSF_HI, hi);
        @(posedge clk);
        @(negedge clk);
        if (tsf_val !== {hi, lo}) begin
            $display("ERR tsf_runtime_val_o exp %h got %h", {hi, lo}, tsf_val);
            err_val++;
        end
        check_us_period({hi, lo});

        mac = rand48();
        bssid = rand48();
        reg_write(`XPU_REG_MAC_LO, mac[31:0]);
        reg_write(`XPU_REG_MAC_HI, {16'h0, mac[47:32]});
        reg_write(`XPU_REG_BSSID_LO, bssid[31:0]);
        reg_write(`XPU_REG_BSSID_HI, {16'h0, bssid[47:32]});

        for (int f = 0; f < N_FRAMES; f++) begin
            r = $urandom();
            cfg = {r[4:1], ($urandom() % 4 == 0)};
            max_len = 16'(24 + $urandom() % 17);
            reg_write(`XPU_REG_FILTER, {27'h0, cfg});
            reg_write(`XPU_REG_MAX_LEN, {16'h0, max_len});
            send_frame();
        end
        repeat (5) @(posedge clk);

        if (n_dec != N_FRAMES) begin
            $display("expected %0d decision strobes but saw %0d", N_FRAMES, n_dec);
            err_proto++;
        end
        $display("errors: value %0d, protocol %0d", err_val, err_proto);
        if (err_val == 0 && err_proto == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+common
common/xpu_pkg.sv
verilog/xpu_regs.sv
verilog/tsf_timer.sv
rx_parse/rx_hdr_parse.sv
rx_parse/pkt_filter.sv
verilog/xpu_top.sv
tb/tb_clkgen.sv
tb/tb_xpu.sv

// File: run_sim.sh
#!/bin/sh
# build and run the xpu testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_xpu \
    --Mdir obj_dir -o sim_xpu

./obj_dir/sim_xpu > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
exit 0
